// ==== tests/decodeStim.txt ====
#name instr cmp flush upExc instrValid stall valid regWrite destSel wbSel aluOp shamtSrc extOp memRead memWrite memSize hiLoWrite mulDivOp npcOp likelyFlush exc
add        00221820 0 0 00 1 0 1 1 1 0 00 0 0 0 0 0 0 0 0 0 00
subu       00221823 0 0 00 1 0 1 1 1 0 10 0 0 0 0 0 0 0 0 0 00
nor        00221827 0 0 00 1 0 1 1 1 0 04 0 0 0 0 0 0 0 0 0 00
sltu       0022182b 0 0 00 1 0 1 1 1 0 0a 0 0 0 0 0 0 0 0 0 00
sra        00021903 0 0 00 1 0 1 1 1 0 08 1 0 0 0 0 0 0 0 0 00
srlv       00221806 0 0 00 1 0 1 1 1 0 07 0 0 0 0 0 0 0 0 0 00
addi       2022ffff 0 0 00 1 0 1 1 0 0 00 0 1 0 0 0 0 0 0 0 00
sltiu      2c220005 0 0 00 1 0 1 1 0 0 0a 0 1 0 0 0 0 0 0 0 00
ori        342200ff 0 0 00 1 0 1 1 0 0 02 0 0 0 0 0 0 0 0 0 00
lui        3c021234 0 0 00 1 0 1 1 0 1 1f 0 2 0 0 0 0 0 0 0 00
lbu        90220004 0 0 00 1 0 1 1 0 4 00 0 1 1 0 1 0 0 0 0 00
lh         84220004 0 0 00 1 0 1 1 0 4 00 0 1 1 0 2 0 0 0 0 00
lw         8c220004 0 0 00 1 0 1 1 0 4 00 0 1 1 0 4 0 0 0 0 00
sb         a0220004 0 0 00 1 0 1 0 0 0 00 0 1 0 1 0 0 0 0 0 00
sw         ac220004 0 0 00 1 0 1 0 0 0 00 0 1 0 1 4 0 0 0 0 00
mult       00220018 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 1 1 0 0 00
divu       0022001b 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 1 2 0 0 00
mthi       00200011 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 1 0 0 0 00
mflo       00001812 0 0 00 1 0 1 1 1 2 1f 0 0 0 0 0 0 0 0 0 00
beqTaken   10220004 4 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
beqNot     10220004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 00
bneTaken   14220004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
bneNot     14220004 4 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 00
blezZero   18200004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
blezPos    18200004 1 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 00
bgtzPos    1c200004 1 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
bgezNeg    04210004 2 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 00
bltzNeg    04200004 2 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
bgezalZero 04310004 0 0 00 1 0 1 1 2 3 1f 0 0 0 0 0 0 0 1 0 00
bltzalPos  04300004 1 0 00 1 0 1 1 2 3 1f 0 0 0 0 0 0 0 0 0 00
j          08000010 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 2 0 00
jal        0c000010 0 0 00 1 0 1 1 2 3 1f 0 0 0 0 0 0 0 2 0 00
jr         03e00008 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 0 0 3 0 00
jalr       0020f809 0 0 00 1 0 1 1 1 3 1f 0 0 0 0 0 0 0 3 0 00
beqlTaken  50220004 4 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 1 0 00
beqlNot    50220004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 1 00
bgtzlNot   5c200004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 1 00
bgezallPos 04330004 1 0 00 1 0 1 1 2 3 1f 0 0 0 0 0 0 0 1 0 00
blezlBadRt 58210004 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 2a
reserved   fc000000 0 0 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 2a
riFlushed  fc000000 0 1 00 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 00
break      0000000d 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 0 0 0 0 29
syscall    0000000c 0 0 00 1 0 1 0 1 0 1f 0 0 0 0 0 0 0 0 0 28
upOverSys  0000000c 0 0 25 1 0 1 0 1 0 1f 0 0 0 0 0 0 0 0 0 25
upOverRi   fc000000 0 0 24 1 0 1 0 0 0 1f 0 0 0 0 0 0 0 0 0 24
holdLoad   00221820 0 0 00 1 0 1 1 1 0 00 0 0 0 0 0 0 0 0 0 00
stallHold  ac220004 0 0 00 0 1 1 1 1 0 00 0 0 0 0 0 0 0 0 0 00
stallHold2 fc000000 0 0 00 1 1 1 1 1 0 00 0 0 0 0 0 0 0 0 0 00
bubble     00000000 0 0 00 0 0 0 1 1 0 06 1 0 0 0 0 0 0 0 0 00

// ==== vlog.f ====
hdl/mipsDecodePkg.sv
hdl/instrClassifier.sv
hdl/aluControl.sv
hdl/branchResolver.sv
hdl/exceptionDetect.sv
hdl/decodeStageReg.sv
hdl/mipsDecodeTop.sv
tests/tbMipsDecode.sv

// ==== Bender.yml ====
package:
  name: mips_decode

sources:
  - files:
      - hdl/mipsDecodePkg.sv
      - hdl/instrClassifier.sv
      - hdl/aluControl.sv
      - hdl/branchResolver.sv
      - hdl/exceptionDetect.sv
      - hdl/decodeStageReg.sv
      - hdl/mipsDecodeTop.sv
  - target: simulation
    files:
      - tests/tbMipsDecode.sv

// ==== tests/tbMipsDecode.sv ====
module tbMipsDecode import mipsDecodePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam string stimPath = "tests/decodeStim.txt";

	logic        clk = 1'b0;
	logic        rst;
	instrWord_t  instr;
	logic        instrValid;
	logic        stall;
	cmpFlags_t   cmp;
	logic        ifFlush;
	excInfo_t    upExc;
	decodeCtrl_t ctrl;
	logic        ctrlValid;

	int          cycles = 0;
	int          cycleLimit = 20; // Raised once the stimulus is counted
	string       rowName;
	logic [31:0] fld [21]; // Columns after the name in file order
	instrWord_t  loadedInstr = '0; // Instruction held by the stage register

	mipsDecodeTop DUT (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.cmp        (cmp),
		.ifFlush    (ifFlush),
		.upExc      (upExc),
		.ctrl       (ctrl),
		.ctrlValid  (ctrlValid)
	);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Error: run did not finish within %0d cycles", cycleLimit);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// HI side select and multiply/divide start from the SPECIAL function field
	function automatic logic [1:0] hiLoFlags(input instrWord_t w);
		logic isSpecial;
		logic hiSide;
		logic startMd;
		isSpecial = (w.r.op == opSpecial);
		hiSide = isSpecial && (w.r.funct == fnMfhi || w.r.funct == fnMthi);
		startMd = isSpecial && (w.r.funct == fnMult || w.r.funct == fnMultu ||
			w.r.funct == fnDiv || w.r.funct == fnDivu);
		return {hiSide, startMd};
	endfunction

	task automatic checkAlu(input string name, input aluCtrl_t exp, input aluCtrl_t act);
		if (act !== exp) begin
			$display("Error %s: alu ctrl expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	// Register, HI/LO and data memory write controls
	task automatic checkMem(input string name, input decodeCtrl_t exp, input decodeCtrl_t act);
		logic [8:0] e;
		logic [8:0] a;
		e = {exp.regWrite, exp.hiLoWrite, exp.hiLoRdHi, exp.mulDivStart, exp.memRead,
			exp.memWrite, exp.memSize};
		a = {act.regWrite, act.hiLoWrite, act.hiLoRdHi, act.mulDivStart, act.memRead,
			act.memWrite, act.memSize};
		if (a !== e) begin
			$display({"Error %s: regWr hiLoWr hiSel mdStart memRd memWr memSize",
				" expected %b actual %b"}, name, e, a);
			abortRun();
		end
	endtask

	task automatic checkNpc(input string name, input npcOp_t exp, input npcOp_t act,
			input logic actJump);
		if (act !== exp) begin
			$display("Error %s: npcOp expected %0d actual %0d", name, exp, act);
			abortRun();
		end
		if (actJump !== (exp != npcSeq)) begin // Any redirect counts as a jump
			$display("Error %s: jump expected %b actual %b", name, exp != npcSeq, actJump);
			abortRun();
		end
	endtask

	task automatic checkFlush(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: likelyFlush expected %b actual %b", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkExc(input string name, input excInfo_t exp, input excInfo_t act);
		if (act !== exp) begin
			$display("Error %s: exc expected %h actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkValid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: ctrlValid expected %b actual %b", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkBundle(input string name, input logic expValid, input decodeCtrl_t exp);
		checkValid(name, expValid, ctrlValid);
		checkAlu(name, exp.alu, ctrl.alu);
		checkMem(name, exp, ctrl);
		checkNpc(name, exp.npcOp, ctrl.npcOp, ctrl.jump);
		checkFlush(name, exp.likelyFlush, ctrl.likelyFlush);
		checkExc(name, exp.exc, ctrl.exc);
	endtask

	// Loads the next data line into rowName and fld and skips header lines
	task automatic readRow(input int fd, output bit got);
		string tok;
		int    n;
		int    k;
		got = 1'b0;
		while (!got && $fscanf(fd, "%s", rowName) == 1) begin
			for (k = 0; k < 21; k++) begin
				if ($fscanf(fd, "%s", tok) != 1) begin
					$display("Error: stimulus line %s has too few columns", rowName);
					abortRun();
				end
				n = $sscanf(tok, "%h", fld[k]);
			end
			got = (rowName[0] != "#");
		end
	endtask

	task automatic countRows(output int n);
		int fd;
		bit got;
		n = 0;
		fd = $fopen(stimPath, "r");
		if (fd == 0) begin
			$display("Error: cannot open stimulus file %s", stimPath);
			abortRun();
		end
		readRow(fd, got);
		while (got) begin
			n++;
			readRow(fd, got);
		end
		$fclose(fd);
	endtask

	// Drive the DUT inputs and build the expected bundle from one line
	task automatic applyRow(output decodeCtrl_t exp);
		instr = fld[0];
		cmp = fld[1][2:0];
		ifFlush = fld[2][0];
		upExc = fld[3][5:0];
		instrValid = fld[4][0];
		stall = fld[5][0];
		if (!stall)
			loadedInstr = instr;
		exp = '0;
		exp.regWrite = fld[7][0];
		exp.alu.destSel = destSel_t'(fld[8][1:0]);
		exp.alu.wbSel = wbSel_t'(fld[9][2:0]);
		exp.alu.aluOp = aluOp_t'(fld[10][4:0]);
		exp.alu.shamtSrc = fld[11][0];
		exp.alu.extOp = extOp_t'(fld[12][1:0]);
		exp.memRead = fld[13][0];
		exp.memWrite = fld[14][0];
		exp.memSize = memSize_t'(fld[15][2:0]);
		exp.hiLoWrite = fld[16][0];
		{exp.hiLoRdHi, exp.mulDivStart} = hiLoFlags(loadedInstr);
		exp.alu.mulDivOp = mulDivOp_t'(fld[17][1:0]);
		exp.npcOp = npcOp_t'(fld[18][1:0]);
		exp.likelyFlush = fld[19][0];
		exp.exc = fld[20][5:0];
	endtask

	initial begin
		int          fd;
		int          nRows;
		bit          got;
		decodeCtrl_t exp;
		rst = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		cmp = '0;
		ifFlush = 1'b0;
		upExc = '0;
		countRows(nRows);
		cycleLimit = nRows * 2 + 20;
		repeat (2) @(posedge clk);
		#2 rst = 1'b1;
		checkBundle("afterReset", 1'b0, '0);
		@(posedge clk); // Settle flag drops at this edge
		#2;
		fd = $fopen(stimPath, "r");
		readRow(fd, got);
		while (got) begin
			applyRow(exp);
			@(posedge clk);
			#1;
			checkBundle(rowName, fld[6][0], exp);
			#1;
			readRow(fd, got);
		end
		$fclose(fd);
		if (nRows == 0) begin
			$display("Error: stimulus file holds no test lines");
			abortRun();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// ==== hdl/mipsDecodeTop.sv ====
module mipsDecodeTop import mipsDecodePkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  instrWord_t  instr,
	input  logic        instrValid,
	input  logic        stall,
	input  cmpFlags_t   cmp,
	input  logic        ifFlush,
	input  excInfo_t    upExc,
	output decodeCtrl_t ctrl,
	output logic        ctrlValid
);

	instrClass_t cls;
	aluCtrl_t    aluCtl;
	npcOp_t      npcOp;
	logic        jump;
	logic        likelyFlush;
	excInfo_t    exc;
	decodeCtrl_t ctrlNext;

	instrClassifier uClassifier (
		.instr (instr),
		.cls   (cls)
	);

	aluControl uAluControl (
		.instr (instr),
		.cls   (cls),
		.alu   (aluCtl)
	);

	branchResolver uBranch (
		.cls         (cls),
		.cmp         (cmp),
		.npcOp       (npcOp),
		.jump        (jump),
		.likelyFlush (likelyFlush)
	);

	exceptionDetect uExc (
		.clk     (clk),
		.rst     (rst),
		.cls     (cls),
		.ifFlush (ifFlush),
		.upExc   (upExc),
		.exc     (exc)
	);

	assign ctrlNext = '{
		regWrite:    cls.regWrite,
		memRead:     cls.memRead,
		memWrite:    cls.memWrite,
		memSize:     cls.memSize,
		hiLoWrite:   cls.hiLoWrite,
		hiLoRdHi:    cls.hiLoRdHi,
		mulDivStart: cls.mulDivStart,
		alu:         aluCtl,
		npcOp:       npcOp,
		jump:        jump,
		likelyFlush: likelyFlush,
		exc:         exc
	};

	decodeStageReg uStage (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.stall      (stall),
		.ctrlIn     (ctrlNext),
		.ctrl       (ctrl),
		.ctrlValid  (ctrlValid)
	);

endmodule

// ==== hdl/decodeStageReg.sv ====
module decodeStageReg import mipsDecodePkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        instrValid,
	input  logic        stall,
	input  decodeCtrl_t ctrlIn,
	output decodeCtrl_t ctrl,
	output logic        ctrlValid
);

	always_ff @(posedge clk) begin
		if (!rst) begin
			ctrl <= '0; // seq fetch, no writes, no exception
			ctrlValid <= 1'b0;
		end else if (!stall) begin
			ctrl <= ctrlIn;
			ctrlValid <= instrValid;
		end
	end

endmodule

// ==== hdl/exceptionDetect.sv ====
module exceptionDetect import mipsDecodePkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  instrClass_t cls,
	input  logic        ifFlush,
	input  excInfo_t    upExc,
	output excInfo_t    exc
);

	logic settle; // High until first cycle out of reset

	always_ff @(posedge clk) begin
		if (!rst)
			settle <= 1'b1;
		else
			settle <= 1'b0;
	end

	always_comb begin
		if (upExc.valid)
			exc = upExc; // Fetch-side fault wins
		else if (!cls.known && !ifFlush && !settle)
			exc = '{valid: 1'b1, code: excRi};
		else if (cls.isBreak)
			exc = '{valid: 1'b1, code: excBp};
		else if (cls.isSyscall)
			exc = '{valid: 1'b1, code: excSys};
		else
			exc = '0;
	end

endmodule

// ==== hdl/branchResolver.sv ====
module branchResolver import mipsDecodePkg::*; (
	input  instrClass_t cls,
	input  cmpFlags_t   cmp,
	output npcOp_t      npcOp,
	output logic        jump,
	output logic        likelyFlush
);

	logic taken;
	logic rsNeg;
	logic rsPos;

	assign rsNeg = (cmp.rsSign == signNeg);
	assign rsPos = (cmp.rsSign == signPos);

	always_comb begin
		case (cls.branchCond)
			brEq:    taken = cmp.eq;
			brNe:    taken = !cmp.eq;
			brGez:   taken = !rsNeg;
			brLtz:   taken = rsNeg;
			brLez:   taken = !rsPos; // Zero or negative
			brGtz:   taken = rsPos;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (taken)
			npcOp = npcBranch;
		else if (cls.jumpKind == jkAbs)
			npcOp = npcJumpAbs;
		else if (cls.jumpKind == jkReg)
			npcOp = npcJumpReg;
		else
			npcOp = npcSeq;
	end

	assign jump = (npcOp != npcSeq);

	// Delay slot is squashed only when a likely branch falls through
	assign likelyFlush = cls.likely && !taken;

endmodule

// ==== hdl/aluControl.sv ====
module aluControl import mipsDecodePkg::*; (
	input  instrWord_t  instr,
	input  instrClass_t cls,
	output aluCtrl_t    alu
);

	always_comb begin
		alu.aluOp = aluNone;
		alu.shamtSrc = 1'b0;
		alu.extOp = extZero;
		alu.mulDivOp = mdMultu;
		alu.destSel = destRt;
		alu.wbSel = wbAlu;
		case (instr.i.op)
			opSpecial: begin
				alu.destSel = destRd;
				case (instr.r.funct)
					fnAdd:   alu.aluOp = aluAdd;
					fnAddu:  alu.aluOp = aluAddu;
					fnSub:   alu.aluOp = aluSub;
					fnSubu:  alu.aluOp = aluSubu;
					fnAnd:   alu.aluOp = aluAnd;
					fnOr:    alu.aluOp = aluOr;
					fnXor:   alu.aluOp = aluXor;
					fnNor:   alu.aluOp = aluNor;
					fnSlt:   alu.aluOp = aluSlt;
					fnSltu:  alu.aluOp = aluSltu;
					fnSllv:  alu.aluOp = aluSll;
					fnSrlv:  alu.aluOp = aluSrl;
					fnSrav:  alu.aluOp = aluSra;
					fnSll, fnSrl, fnSra: begin
						alu.shamtSrc = 1'b1;
						alu.aluOp = (instr.r.funct == fnSll) ? aluSll :
							(instr.r.funct == fnSrl) ? aluSrl : aluSra;
					end
					fnMult:  alu.mulDivOp = mdMult;
					fnDivu:  alu.mulDivOp = mdDivu;
					fnDiv:   alu.mulDivOp = mdDiv;
					default: ;
				endcase
			end
			opAddi:  {alu.aluOp, alu.extOp} = {aluAdd, extSign};
			opAddiu: {alu.aluOp, alu.extOp} = {aluAddu, extSign};
			opSlti:  {alu.aluOp, alu.extOp} = {aluSlt, extSign};
			opSltiu: {alu.aluOp, alu.extOp} = {aluSltu, extSign};
			opAndi:  alu.aluOp = aluAnd;
			opOri:   alu.aluOp = aluOr;
			opXori:  alu.aluOp = aluXor;
			opLui:   alu.extOp = extUpper;
			default: ;
		endcase

		if (cls.memRead || cls.memWrite) begin // Address = rs + simm
			alu.aluOp = aluAdd;
			alu.extOp = extSign;
		end

		if (cls.link) begin
			alu.wbSel = wbPcLink;
			if (instr.i.op != opSpecial) // JALR keeps rd
				alu.destSel = destLink31;
		end else if (cls.memRead) begin
			alu.wbSel = wbMem;
		end else if (instr.i.op == opSpecial &&
				(instr.r.funct == fnMfhi || instr.r.funct == fnMflo)) begin
			alu.wbSel = wbHiLo;
		end else if (instr.i.op == opLui) begin
			alu.wbSel = wbUpperImm;
		end
	end

endmodule

// ==== hdl/instrClassifier.sv ====
module instrClassifier import mipsDecodePkg::*; (
	input  instrWord_t  instr,
	output instrClass_t cls
);

	always_comb begin
		cls = '0;
		cls.branchCond = brNone;
		cls.jumpKind = jkNone;
		case (instr.i.op)
			opSpecial: begin
				case (instr.r.funct)
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
					fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
						cls.known = 1'b1;
						cls.regWrite = 1'b1;
					end
					fnJr: begin
						cls.known = 1'b1;
						cls.jumpKind = jkReg;
					end
					fnJalr: begin
						cls.known = 1'b1;
						cls.jumpKind = jkReg;
						cls.link = 1'b1;
						cls.regWrite = 1'b1;
					end
					fnMfhi, fnMflo: begin
						cls.known = 1'b1;
						cls.regWrite = 1'b1;
						cls.hiLoRdHi = (instr.r.funct == fnMfhi);
					end
					fnMthi, fnMtlo: begin
						cls.known = 1'b1;
						cls.hiLoWrite = 1'b1;
						cls.hiLoRdHi = (instr.r.funct == fnMthi);
					end
					fnMult, fnMultu, fnDiv, fnDivu: begin
						cls.known = 1'b1;
						cls.hiLoWrite = 1'b1;
						cls.mulDivStart = 1'b1;
					end
					fnBreak: begin
						cls.known = 1'b1;
						cls.isBreak = 1'b1;
					end
					fnSyscall: begin
						cls.known = 1'b1;
						cls.isSyscall = 1'b1;
					end
					default: ;
				endcase
			end
			opRegimm: begin
				if (instr.i.rt inside {rtBltz, rtBgez, rtBltzl, rtBgezl,
						rtBltzal, rtBgezal, rtBltzall, rtBgezall}) begin
					cls.known = 1'b1;
					cls.branchCond = instr.i.rt[0] ? brGez : brLtz;
					cls.likely = instr.i.rt[1];   // rt bit 1 marks likely
					cls.link = instr.i.rt[4];     // AL forms write r31
					cls.regWrite = instr.i.rt[4];
				end
			end
			opBeq, opBeql, opBne, opBnel: begin
				cls.known = 1'b1;
				cls.branchCond = instr.i.op[0] ? brNe : brEq;
				cls.likely = instr.i.op[4];
			end
			opBlez, opBgtz: begin
				cls.known = 1'b1;
				cls.branchCond = instr.i.op[0] ? brGtz : brLez;
			end
			opBlezl, opBgtzl: begin
				if (instr.i.rt == 5'd0) begin // Nonzero rt is reserved
					cls.known = 1'b1;
					cls.branchCond = instr.i.op[0] ? brGtz : brLez;
					cls.likely = 1'b1;
				end
			end
			opJ: begin
				cls.known = 1'b1;
				cls.jumpKind = jkAbs;
			end
			opJal: begin
				cls.known = 1'b1;
				cls.jumpKind = jkAbs;
				cls.link = 1'b1;
				cls.regWrite = 1'b1;
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				cls.known = 1'b1;
				cls.regWrite = 1'b1;
			end
			opLb, opLbu, opLh, opLhu, opLw: begin
				cls.known = 1'b1;
				cls.regWrite = 1'b1;
				cls.memRead = 1'b1;
				case (instr.i.op)
					opLb:    cls.memSize = memByte;
					opLbu:   cls.memSize = memByteU;
					opLh:    cls.memSize = memHalf;
					opLhu:   cls.memSize = memHalfU;
					default: cls.memSize = memWord;
				endcase
			end
			opSb, opSh, opSw: begin
				cls.known = 1'b1;
				cls.memWrite = 1'b1;
				case (instr.i.op)
					opSb:    cls.memSize = memByte;
					opSh:    cls.memSize = memHalf;
					default: cls.memSize = memWord;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/mipsDecodePkg.sv ====
package mipsDecodePkg;

	// Primary opcodes
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm  = 6'b000001;
	localparam logic [5:0] opJ       = 6'b000010;
	localparam logic [5:0] opJal     = 6'b000011;
	localparam logic [5:0] opBeq     = 6'b000100;
	localparam logic [5:0] opBne     = 6'b000101;
	localparam logic [5:0] opBlez    = 6'b000110;
	localparam logic [5:0] opBgtz    = 6'b000111;
	localparam logic [5:0] opAddi    = 6'b001000;
	localparam logic [5:0] opAddiu   = 6'b001001;
	localparam logic [5:0] opSlti    = 6'b001010;
	localparam logic [5:0] opSltiu   = 6'b001011;
	localparam logic [5:0] opAndi    = 6'b001100;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opXori    = 6'b001110;
	localparam logic [5:0] opLui     = 6'b001111;
	localparam logic [5:0] opBeql    = 6'b010100;
	localparam logic [5:0] opBnel    = 6'b010101;
	localparam logic [5:0] opBlezl   = 6'b010110;
	localparam logic [5:0] opBgtzl   = 6'b010111;
	localparam logic [5:0] opLb      = 6'b100000;
	localparam logic [5:0] opLh      = 6'b100001;
	localparam logic [5:0] opLw      = 6'b100011;
	localparam logic [5:0] opLbu     = 6'b100100;
	localparam logic [5:0] opLhu     = 6'b100101;
	localparam logic [5:0] opSb      = 6'b101000;
	localparam logic [5:0] opSh      = 6'b101001;
	localparam logic [5:0] opSw      = 6'b101011;

	// SPECIAL function field
	localparam logic [5:0] fnSll     = 6'b000000;
	localparam logic [5:0] fnSrl     = 6'b000010;
	localparam logic [5:0] fnSra     = 6'b000011;
	localparam logic [5:0] fnSllv    = 6'b000100;
	localparam logic [5:0] fnSrlv    = 6'b000110;
	localparam logic [5:0] fnSrav    = 6'b000111;
	localparam logic [5:0] fnJr      = 6'b001000;
	localparam logic [5:0] fnJalr    = 6'b001001;
	localparam logic [5:0] fnSyscall = 6'b001100;
	localparam logic [5:0] fnBreak   = 6'b001101;
	localparam logic [5:0] fnMfhi    = 6'b010000;
	localparam logic [5:0] fnMthi    = 6'b010001;
	localparam logic [5:0] fnMflo    = 6'b010010;
	localparam logic [5:0] fnMtlo    = 6'b010011;
	localparam logic [5:0] fnMult    = 6'b011000;
	localparam logic [5:0] fnMultu   = 6'b011001;
	localparam logic [5:0] fnDiv     = 6'b011010;
	localparam logic [5:0] fnDivu    = 6'b011011;
	localparam logic [5:0] fnAdd     = 6'b100000;
	localparam logic [5:0] fnAddu    = 6'b100001;
	localparam logic [5:0] fnSub     = 6'b100010;
	localparam logic [5:0] fnSubu    = 6'b100011;
	localparam logic [5:0] fnAnd     = 6'b100100;
	localparam logic [5:0] fnOr      = 6'b100101;
	localparam logic [5:0] fnXor     = 6'b100110;
	localparam logic [5:0] fnNor     = 6'b100111;
	localparam logic [5:0] fnSlt     = 6'b101010;
	localparam logic [5:0] fnSltu    = 6'b101011;

	// REGIMM rt field
	localparam logic [4:0] rtBltz    = 5'b00000;
	localparam logic [4:0] rtBgez    = 5'b00001;
	localparam logic [4:0] rtBltzl   = 5'b00010;
	localparam logic [4:0] rtBgezl   = 5'b00011;
	localparam logic [4:0] rtBltzal  = 5'b10000;
	localparam logic [4:0] rtBgezal  = 5'b10001;
	localparam logic [4:0] rtBltzall = 5'b10010;
	localparam logic [4:0] rtBgezall = 5'b10011;

	localparam logic [4:0] excSys = 5'd8;
	localparam logic [4:0] excBp  = 5'd9;
	localparam logic [4:0] excRi  = 5'd10;

	localparam logic [1:0] signNeg = 2'b10; // rs sign flag encodings
	localparam logic [1:0] signPos = 2'b01;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFmt_t;

	typedef union packed {
		rFmt_t r;
		iFmt_t i;
	} instrWord_t;

	typedef struct packed {
		logic       eq;     // rs == rt
		logic [1:0] rsSign; // 10 neg, 01 pos, 00 zero
	} cmpFlags_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] code;
	} excInfo_t;

	typedef enum logic [4:0] {
		aluAdd = 5'd0, aluSub = 5'd1, aluOr = 5'd2, aluAnd = 5'd3, aluNor = 5'd4,
		aluXor = 5'd5, aluSll = 5'd6, aluSrl = 5'd7, aluSra = 5'd8, aluSlt = 5'd9,
		aluSltu = 5'd10, aluAddu = 5'd12, aluSubu = 5'd16, aluNone = 5'd31
	} aluOp_t;

	typedef enum logic [1:0] {mdMultu, mdMult, mdDivu, mdDiv} mulDivOp_t;
	typedef enum logic [1:0] {extZero, extSign, extUpper} extOp_t;
	typedef enum logic [1:0] {destRt, destRd, destLink31} destSel_t;
	typedef enum logic [2:0] {wbAlu, wbUpperImm, wbHiLo, wbPcLink, wbMem} wbSel_t;
	typedef enum logic [2:0] {memByte, memByteU, memHalf, memHalfU, memWord} memSize_t;
	typedef enum logic [1:0] {npcSeq, npcBranch, npcJumpAbs, npcJumpReg} npcOp_t;
	typedef enum logic [1:0] {jkNone, jkAbs, jkReg} jumpKind_t;

	typedef enum logic [2:0] {
		brEq = 3'd0, brNe = 3'd1, brGez = 3'd2, brLtz = 3'd3,
		brLez = 3'd4, brGtz = 3'd5, brNone = 3'd7
	} branchCond_t;

	typedef struct packed {
		logic        known;
		logic        isBreak;
		logic        isSyscall;
		branchCond_t branchCond;
		logic        likely;
		jumpKind_t   jumpKind;
		logic        link;
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		memSize_t    memSize;
		logic        hiLoWrite;
		logic        hiLoRdHi; // HI side for MFHI and MTHI
		logic        mulDivStart;
	} instrClass_t;

	typedef struct packed {
		aluOp_t    aluOp;
		logic      shamtSrc; // Shift amount from shamt field
		extOp_t    extOp;
		mulDivOp_t mulDivOp;
		destSel_t  destSel;
		wbSel_t    wbSel;
	} aluCtrl_t;

	typedef struct packed {
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     hiLoWrite;
		logic     hiLoRdHi;
		logic     mulDivStart;
		aluCtrl_t alu;
		npcOp_t   npcOp;
		logic     jump;
		logic     likelyFlush;
		excInfo_t exc;
	} decodeCtrl_t;

endpackage
